/* flist.f */
verilog/video_pkg.sv
verilog/beam_timing.sv
verilog/line_reader.sv
verilog/pixel_output.sv
verilog/ram2video.sv
testbench/ram2video_tb.sv

/* testbench/ram2video_tb.sv */
module ram2video_tb;
    import video_pkg::*;

    localparam int   H_TOTAL      = 48;
    localparam int   H_VISIBLE    = 32;
    localparam int   H_SYNC_START = 36;
    localparam int   H_SYNC_WIDTH = 4;
    localparam logic H_SYNC_POL   = 1'b1;
    localparam int   V_LINES_EVEN = 20;
    localparam int   V_LINES_ODD  = 21;
    localparam int   V_VISIBLE    = 14;
    localparam int   V_SYNC_START = 16;
    localparam int   V_SYNC_WIDTH = 2;
    localparam logic V_SYNC_POL   = 1'b0;
    localparam int   CAP_X_START  = 4;
    localparam int   CAP_Y_START  = 2;
    localparam int   CAP_LINES    = 10;
    localparam int   LINE_WORDS   = 6;
    localparam int   RAM_WORDS    = 40;
    localparam int   PIXEL_REPEAT = 4;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 20;
    localparam int PIPE_DEPTH   = 3;
    // three frames of even, odd and even length
    localparam int RUN_CYCLES   = (2 * V_LINES_EVEN + V_LINES_ODD) * H_TOTAL;
    localparam int WATCHDOG     = (2 * RUN_CYCLES + RESET_CYCLES + IDLE_CYCLES) * PERIOD;
    // the last line base reads past RAM_WORDS
    localparam int MEM_WORDS    = 1 << ADDR_W;

    logic      clock = 1'b0;
    logic      reset;
    logic      starttrigger;
    ram_addr_t rdaddr;
    pixel_t    rddata;
    pixel_t    video_out;
    logic      hsync;
    logic      vsync;
    logic      draw_area;
    logic      fullcycle;

    pixel_t    mem [0:MEM_WORDS-1];
    integer    seed;
    logic      started;
    int        run_cycles;
    int        vs_seen;
    coord_t    tx;
    coord_t    ty;
    field_t    tfield;
    ram_addr_t base;
    string     test_name;

    // expected values with the oldest position first
    pixel_t    pix_q[$];
    logic      hs_q[$];
    logic      vs_q[$];
    logic      da_q[$];
    ram_addr_t addr_q[$];

    ram2video #(
        .H_TOTAL      (H_TOTAL),
        .H_VISIBLE    (H_VISIBLE),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_WIDTH (H_SYNC_WIDTH),
        .H_SYNC_POL   (H_SYNC_POL),
        .V_LINES_EVEN (V_LINES_EVEN),
        .V_LINES_ODD  (V_LINES_ODD),
        .V_VISIBLE    (V_VISIBLE),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_WIDTH (V_SYNC_WIDTH),
        .V_SYNC_POL   (V_SYNC_POL),
        .CAP_X_START  (CAP_X_START),
        .CAP_Y_START  (CAP_Y_START),
        .CAP_LINES    (CAP_LINES),
        .LINE_WORDS   (LINE_WORDS),
        .RAM_WORDS    (RAM_WORDS),
        .PIXEL_REPEAT (PIXEL_REPEAT)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .starttrigger (starttrigger),
        .rdaddr       (rdaddr),
        .rddata       (rddata),
        .video_out    (video_out),
        .hsync        (hsync),
        .vsync        (vsync),
        .draw_area    (draw_area),
        .fullcycle    (fullcycle)
    );

    always #(PERIOD / 2) clock = ~clock;

    // line buffer with registered reads
    always @(posedge clock) begin
        rddata <= mem[rdaddr];
    end

    always @(posedge clock) begin
        if (!reset && starttrigger) begin
            started <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // base of the buffer line shown on line y
    function automatic ram_addr_t next_line_base(input coord_t y, input ram_addr_t cur);
        if (y == CAP_Y_START) begin
            return '0;
        end else if (y > CAP_Y_START && y < CAP_Y_START + CAP_LINES) begin
            return (cur < RAM_WORDS - LINE_WORDS) ? ram_addr_t'(cur + LINE_WORDS) : '0;
        end
        return cur;
    endfunction

    function automatic void expected_at(
        input  coord_t    x,
        input  coord_t    y,
        input  ram_addr_t line_base,
        output pixel_t    pix,
        output logic      hs,
        output logic      vs,
        output logic      da,
        output ram_addr_t addr
    );
        logic   in_win;
        pixel_t word;
        in_win = (x >= CAP_X_START) && (x < CAP_X_START + LINE_WORDS * PIXEL_REPEAT)
              && (y >= CAP_Y_START) && (y < CAP_Y_START + CAP_LINES);
        addr = in_win ? ram_addr_t'(line_base + (x - CAP_X_START) / PIXEL_REPEAT) : '0;
        word = mem[addr];
        // bytes come out in reverse order
        pix  = in_win ? {word[7:0], word[15:8], word[23:16]} : '0;
        hs   = (x >= H_SYNC_START && x < H_SYNC_START + H_SYNC_WIDTH) ? H_SYNC_POL : !H_SYNC_POL;
        vs   = (y >= V_SYNC_START && y < V_SYNC_START + V_SYNC_WIDTH) ? V_SYNC_POL : !V_SYNC_POL;
        da   = (x < H_VISIBLE) && (y < V_VISIBLE);
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            fail_stop($sformatf("error %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("error %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input ram_addr_t exp, input ram_addr_t act);
        if (act !== exp) begin
            fail_stop($sformatf("error %s %s expected %0d actual %0d", test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("error %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    // outputs are stable half a cycle after the edge
    always @(negedge clock) begin : compare
        pixel_t    exp_pix;
        logic      exp_hs;
        logic      exp_vs;
        logic      exp_da;
        ram_addr_t exp_addr;
        int        y_last;
        test_name = "reset_idle";
        if (started) begin
            test_name = "frames";
            if (tx == 0) begin
                base = next_line_base(ty, base);
            end
            expected_at(tx, ty, base, exp_pix, exp_hs, exp_vs, exp_da, exp_addr);
            pix_q.push_back(exp_pix);
            hs_q.push_back(exp_hs);
            vs_q.push_back(exp_vs);
            da_q.push_back(exp_da);
            addr_q.push_back(exp_addr);
            // step the model beam along the field's frame length
            y_last = (tfield == field_odd) ? V_LINES_ODD - 1 : V_LINES_EVEN - 1;
            if (tx == H_TOTAL - 1) begin
                tx = '0;
                if (ty == y_last) begin
                    ty     = '0;
                    tfield = (tfield == field_even) ? field_odd : field_even;
                end else begin
                    ty = ty + 1'b1;
                end
            end else begin
                tx = tx + 1'b1;
            end
            run_cycles++;
        end

        // rdaddr lags the position by one cycle
        exp_addr = '0;
        if (addr_q.size() > 1) begin
            exp_addr = addr_q.pop_front();
        end
        check_addr("rdaddr", exp_addr, rdaddr);

        // idle levels until the pipe is full
        exp_pix = '0;
        exp_hs  = !H_SYNC_POL;
        exp_vs  = !V_SYNC_POL;
        exp_da  = 1'b0;
        if (pix_q.size() > PIPE_DEPTH) begin
            exp_pix = pix_q.pop_front();
            exp_hs  = hs_q.pop_front();
            exp_vs  = vs_q.pop_front();
            exp_da  = da_q.pop_front();
        end
        check_pixel("video_out", exp_pix, video_out);
        check_bit("hsync", exp_hs, hsync);
        check_bit("vsync", exp_vs, vsync);
        check_flag("draw_area", exp_da, draw_area);
        check_flag("fullcycle", vs_seen >= 15, fullcycle);
        if (exp_vs == V_SYNC_POL) begin
            vs_seen++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        starttrigger = 1'b0;
        rddata       = '0;
        started      = 1'b0;
        run_cycles   = 0;
        vs_seen      = 0;
        tx           = '0;
        ty           = '0;
        tfield       = field_even;
        base         = '0;
        seed         = 32'h54ac_e2c1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clock);
        starttrigger = 1'b1;
        wait (run_cycles >= RUN_CYCLES + PIPE_DEPTH);
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG);
        fail_stop("timeout, the three frames did not finish before the watchdog expired");
    end

endmodule

/* verilog/beam_timing.sv */
module beam_timing #(
    parameter int   H_TOTAL      = 800,
    parameter int   H_SYNC_START = 656,
    parameter int   H_SYNC_WIDTH = 96,
    parameter logic H_SYNC_POL   = 1'b0,
    parameter int   V_LINES_EVEN = 525,
    parameter int   V_LINES_ODD  = 526,
    parameter int   V_SYNC_START = 490,
    parameter int   V_SYNC_WIDTH = 2,
    parameter logic V_SYNC_POL   = 1'b0
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              starttrigger,
    output logic              running,
    output video_pkg::coord_t beam_x,
    output video_pkg::coord_t beam_y,
    output logic              hsync_raw,
    output logic              vsync_raw
);
    import video_pkg::*;

    localparam coord_t X_LAST      = coord_t'(H_TOTAL - 1);
    localparam coord_t Y_LAST_EVEN = coord_t'(V_LINES_EVEN - 1);
    localparam coord_t Y_LAST_ODD  = coord_t'(V_LINES_ODD - 1);
    localparam coord_t HS_BEGIN    = coord_t'(H_SYNC_START);
    localparam coord_t HS_END      = coord_t'(H_SYNC_START + H_SYNC_WIDTH);
    localparam coord_t VS_BEGIN    = coord_t'(V_SYNC_START);
    localparam coord_t VS_END      = coord_t'(V_SYNC_START + V_SYNC_WIDTH);

    field_t field;
    coord_t y_last;
    logic   x_wrap;
    logic   y_wrap;
    logic   h_active;
    logic   v_active;

    // last line of the frame depends on the field
    assign y_last = (field == field_odd) ? Y_LAST_ODD : Y_LAST_EVEN;

    assign x_wrap = (beam_x == X_LAST);
    assign y_wrap = (beam_y == y_last);

    assign h_active = (beam_x >= HS_BEGIN) && (beam_x < HS_END);
    // vsync covers whole lines only
    assign v_active = (beam_y >= VS_BEGIN) && (beam_y < VS_END);

    ////////////////////////////////////////////////////////////
    // start
    ////////////////////////////////////////////////////////////

    // once started, runs until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
        end else if (!running && starttrigger) begin
            running <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // beam counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beam_x <= '0;
            beam_y <= '0;
            field  <= field_even;
        end else if (running) begin
            if (x_wrap) begin
                beam_x <= '0;
                if (y_wrap) begin
                    beam_y <= '0;
                    // next frame uses the other length
                    field <= (field == field_even) ? field_odd : field_even;
                end else begin
                    beam_y <= beam_y + 1'b1;
                end
            end else begin
                beam_x <= beam_x + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sync levels
    ////////////////////////////////////////////////////////////

    // one cycle behind the beam position
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_raw <= !H_SYNC_POL;
            vsync_raw <= !V_SYNC_POL;
        end else if (running) begin
            if (h_active) begin
                hsync_raw <= H_SYNC_POL;
            end else begin
                hsync_raw <= !H_SYNC_POL;
            end

            if (v_active) begin
                vsync_raw <= V_SYNC_POL;
            end else begin
                vsync_raw <= !V_SYNC_POL;
            end
        end
    end

endmodule

/* verilog/line_reader.sv */
module line_reader #(
    parameter int CAP_X_START  = 0,
    parameter int CAP_Y_START  = 0,
    parameter int CAP_LINES    = 480,
    parameter int LINE_WORDS   = 160,
    parameter int RAM_WORDS    = 16000,
    parameter int PIXEL_REPEAT = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 running,
    input  video_pkg::coord_t    beam_x,
    input  video_pkg::coord_t    beam_y,
    output video_pkg::ram_addr_t rdaddr,
    output logic                 in_capture
);
    import video_pkg::*;

    localparam int REP_W = (PIXEL_REPEAT > 1) ? $clog2(PIXEL_REPEAT) : 1;

    localparam coord_t WIN_X_BEGIN = coord_t'(CAP_X_START);
    localparam coord_t WIN_X_LAST  = coord_t'(CAP_X_START + LINE_WORDS * PIXEL_REPEAT - 1);
    localparam coord_t WIN_Y_BEGIN = coord_t'(CAP_Y_START);
    localparam coord_t WIN_Y_LAST  = coord_t'(CAP_Y_START + CAP_LINES - 1);

    localparam ram_addr_t LINE_STEP  = ram_addr_t'(LINE_WORDS);
    localparam ram_addr_t BASE_LIMIT = ram_addr_t'(RAM_WORDS - LINE_WORDS);

    localparam logic [REP_W-1:0] REP_LAST = REP_W'(PIXEL_REPEAT - 1);

    logic             x_in;
    logic             y_in;
    logic             win;
    logic [REP_W-1:0] rep_cnt;
    ram_addr_t        word_idx;
    ram_addr_t        line_base;

    assign x_in = (beam_x >= WIN_X_BEGIN) && (beam_x <= WIN_X_LAST);
    assign y_in = (beam_y >= WIN_Y_BEGIN) && (beam_y <= WIN_Y_LAST);
    assign win  = x_in && y_in;

    ////////////////////////////////////////////////////////////
    // word counter
    ////////////////////////////////////////////////////////////

    // cleared outside the window, so every line starts at word 0
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rep_cnt  <= '0;
            word_idx <= '0;
        end else if (running && x_in) begin
            if (rep_cnt == REP_LAST) begin
                rep_cnt  <= '0;
                word_idx <= word_idx + 1'b1;
            end else begin
                rep_cnt <= rep_cnt + 1'b1;
            end
        end else begin
            rep_cnt  <= '0;
            word_idx <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // line base
    ////////////////////////////////////////////////////////////

    // steps after the last word of a captured line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_base <= '0;
        end else if (running && win && beam_x == WIN_X_LAST) begin
            if (beam_y == WIN_Y_LAST) begin
                // next frame starts at the top of the buffer
                line_base <= '0;
            end else if (line_base < BASE_LIMIT) begin
                line_base <= line_base + LINE_STEP;
            end else begin
                line_base <= '0;
            end
        end
    end

    // address and window flag, one cycle behind the beam
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rdaddr     <= '0;
            in_capture <= 1'b0;
        end else if (running) begin
            in_capture <= win;
            rdaddr     <= win ? (line_base + word_idx) : '0;
        end
    end

endmodule

/* verilog/pixel_output.sv */
module pixel_output #(
    parameter int   H_VISIBLE  = 640,
    parameter int   V_VISIBLE  = 480,
    parameter logic H_SYNC_POL = 1'b0,
    parameter logic V_SYNC_POL = 1'b0
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              running,
    input  video_pkg::coord_t beam_x,
    input  video_pkg::coord_t beam_y,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    input  logic              in_capture,
    input  video_pkg::pixel_t rddata,
    output video_pkg::pixel_t video_out,
    output logic              hsync,
    output logic              vsync,
    output logic              draw_area,
    output logic              fullcycle
);
    import video_pkg::*;

    localparam coord_t VIS_X = coord_t'(H_VISIBLE);
    localparam coord_t VIS_Y = coord_t'(V_VISIBLE);

    localparam logic [3:0] FULL_COUNT = 4'd15;

    coord_t     x_d1;
    coord_t     x_d2;
    coord_t     y_d1;
    coord_t     y_d2;
    logic       hs_d;
    logic       vs_d;
    logic       cap_d;
    logic       run_d1;
    logic       run_d2;
    pixel_t     swapped;
    logic       vs_on;
    logic [3:0] vs_count;

    // ram word holds the bytes in reverse order
    assign swapped = {rddata[7:0], rddata[15:8], rddata[23:16]};

    assign vs_on = (vsync == V_SYNC_POL);

    ////////////////////////////////////////////////////////////
    // alignment with rddata
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        x_d1  <= beam_x;
        y_d1  <= beam_y;
        x_d2  <= x_d1;
        y_d2  <= y_d1;
        hs_d  <= hsync_raw;
        vs_d  <= vsync_raw;
        cap_d <= in_capture;
    end

    // outputs hold their idle levels until the pipe is filled
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            run_d1 <= 1'b0;
            run_d2 <= 1'b0;
        end else begin
            run_d1 <= running;
            run_d2 <= run_d1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            hsync     <= !H_SYNC_POL;
            vsync     <= !V_SYNC_POL;
            draw_area <= 1'b0;
        end else if (run_d2) begin
            video_out <= cap_d ? swapped : '0;
            hsync     <= hs_d;
            vsync     <= vs_d;
            draw_area <= (x_d2 < VIS_X) && (y_d2 < VIS_Y);
        end
    end

    // sticky once 15 active vsync cycles were seen
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vs_count  <= '0;
            fullcycle <= 1'b0;
        end else begin
            if (vs_on && vs_count != FULL_COUNT) begin
                vs_count <= vs_count + 1'b1;
            end
            fullcycle <= fullcycle || (vs_on && vs_count == FULL_COUNT - 1'b1);
        end
    end

endmodule

/* verilog/ram2video.sv */
module ram2video #(
    parameter int   H_TOTAL      = 800,
    parameter int   H_VISIBLE    = 640,
    parameter int   H_SYNC_START = 656,
    parameter int   H_SYNC_WIDTH = 96,
    parameter logic H_SYNC_POL   = 1'b0,
    parameter int   V_LINES_EVEN = 525,
    parameter int   V_LINES_ODD  = 526,
    parameter int   V_VISIBLE    = 480,
    parameter int   V_SYNC_START = 490,
    parameter int   V_SYNC_WIDTH = 2,
    parameter logic V_SYNC_POL   = 1'b0,
    parameter int   CAP_X_START  = 0,
    parameter int   CAP_Y_START  = 0,
    parameter int   CAP_LINES    = 480,
    parameter int   LINE_WORDS   = 160,
    parameter int   RAM_WORDS    = 16000,
    parameter int   PIXEL_REPEAT = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 starttrigger,
    output video_pkg::ram_addr_t rdaddr,
    input  video_pkg::pixel_t    rddata,
    output video_pkg::pixel_t    video_out,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 draw_area,
    output logic                 fullcycle
);
    import video_pkg::*;

    logic   running;
    coord_t beam_x;
    coord_t beam_y;
    logic   hsync_raw;
    logic   vsync_raw;
    logic   in_capture;

    ////////////////////////////////////////////////////////////
    // beam, then ram read, then output stage
    ////////////////////////////////////////////////////////////

    beam_timing #(
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_WIDTH (H_SYNC_WIDTH),
        .H_SYNC_POL   (H_SYNC_POL),
        .V_LINES_EVEN (V_LINES_EVEN),
        .V_LINES_ODD  (V_LINES_ODD),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_WIDTH (V_SYNC_WIDTH),
        .V_SYNC_POL   (V_SYNC_POL)
    ) u_beam_timing (
        .clock        (clock),
        .reset        (reset),
        .starttrigger (starttrigger),
        .running      (running),
        .beam_x       (beam_x),
        .beam_y       (beam_y),
        .hsync_raw    (hsync_raw),
        .vsync_raw    (vsync_raw)
    );

    line_reader #(
        .CAP_X_START  (CAP_X_START),
        .CAP_Y_START  (CAP_Y_START),
        .CAP_LINES    (CAP_LINES),
        .LINE_WORDS   (LINE_WORDS),
        .RAM_WORDS    (RAM_WORDS),
        .PIXEL_REPEAT (PIXEL_REPEAT)
    ) u_line_reader (
        .clock        (clock),
        .reset        (reset),
        .running      (running),
        .beam_x       (beam_x),
        .beam_y       (beam_y),
        .rdaddr       (rdaddr),
        .in_capture   (in_capture)
    );

    pixel_output #(
        .H_VISIBLE    (H_VISIBLE),
        .V_VISIBLE    (V_VISIBLE),
        .H_SYNC_POL   (H_SYNC_POL),
        .V_SYNC_POL   (V_SYNC_POL)
    ) u_pixel_output (
        .clock        (clock),
        .reset        (reset),
        .running      (running),
        .beam_x       (beam_x),
        .beam_y       (beam_y),
        .hsync_raw    (hsync_raw),
        .vsync_raw    (vsync_raw),
        .in_capture   (in_capture),
        .rddata       (rddata),
        .video_out    (video_out),
        .hsync        (hsync),
        .vsync        (vsync),
        .draw_area    (draw_area),
        .fullcycle    (fullcycle)
    );

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // beam counters, wide enough for large modes
    localparam int COORD_W = 12;

    // one byte per colour
    localparam int PIXEL_W = 24;

    // line buffer word address
    localparam int ADDR_W = 14;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [COORD_W-1:0] coord_t;

    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef logic [ADDR_W-1:0] ram_addr_t;

    // picks the vertical length of the running frame
    typedef enum logic {
        field_even,
        field_odd
    } field_t;

endpackage
